//--- common/sprw_types_pkg.sv
`default_nettype none

package sprw_types_pkg;

    // lane geometry, fixed by the 32-bit word
    localparam int LANES  = 4;
    localparam int LANE_W = 8;
    localparam int WIDE_W = 16;
    localparam int WORD_W = LANES * LANE_W;

    typedef logic [WORD_W-1:0] word_t;

    // one byte lane
    typedef logic [LANE_W-1:0] lane_t;

    // widened lane, two's complement when signed
    typedef logic [WIDE_W-1:0] wide_t;

    // lane i sits at word bits 8i+7 downto 8i
    typedef lane_t [LANES-1:0] vec_t;

    // four widened lanes, 64 bits in all
    typedef wide_t [LANES-1:0] wide_vec_t;

endpackage

`default_nettype wire

//--- common/sprw_ops_pkg.sv
`default_nettype none

package sprw_ops_pkg;

    // per-lane operation
    typedef enum logic [3:0] {
        LOP_PASS = 4'd0,
        LOP_ADD  = 4'd1,
        LOP_SUB  = 4'd2,
        LOP_MAX  = 4'd3,
        LOP_MIN  = 4'd4,
        LOP_AND  = 4'd5,
        LOP_OR   = 4'd6,
        LOP_XOR  = 4'd7,
        LOP_NAND = 4'd8,
        LOP_NOR  = 4'd9,
        LOP_XNOR = 4'd10,
        LOP_MOVB = 4'd11
    } lane_op_e;

    // cross-lane fold
    typedef enum logic [2:0] {
        ROP_NONE = 3'd0,
        ROP_SUM  = 3'd1,
        ROP_MAX  = 3'd2,
        ROP_MIN  = 3'd3,
        ROP_XOR  = 3'd4
    } red_op_e;

    typedef struct packed {
        lane_op_e lane_op;
        logic     lane_signed;
        logic     sat;
        red_op_e  red_op;
        logic     red_signed;
        logic     rc_we;
    } instr_t;

    // stage 1 contents
    typedef struct packed {
        instr_t               instr;
        sprw_types_pkg::vec_t ra;
        sprw_types_pkg::vec_t rb;
    } issue_t;

    // stage 2 contents
    typedef struct packed {
        sprw_types_pkg::wide_vec_t wide;
        red_op_e                   red_op;
        logic                      red_signed;
        logic                      sat;
        logic                      rc_we;
    } lane_stage_t;

endpackage

`default_nettype wire

//--- sprw_pipe/sprw_issue.sv
`timescale 1ns/1ps
`default_nettype none

module sprw_issue (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   holdn,
    input  wire sprw_ops_pkg::instr_t   instr,
    input  wire sprw_types_pkg::word_t  ra,
    input  wire sprw_types_pkg::word_t  rb,
    output sprw_ops_pkg::issue_t        issued
);

    sprw_ops_pkg::issue_t issue_next;

    // split a word into its byte lanes, lane 0 lowest
    function automatic sprw_types_pkg::vec_t word_to_vec(sprw_types_pkg::word_t w);
        sprw_types_pkg::vec_t v;
        for (int i = 0; i < sprw_types_pkg::LANES; i++) begin
            v[i] = w[i*sprw_types_pkg::LANE_W +: sprw_types_pkg::LANE_W];
        end
        return v;
    endfunction

    always_comb begin
        issue_next.instr = instr;
        issue_next.ra    = word_to_vec(ra);
        issue_next.rb    = word_to_vec(rb);
    end

    // stage 1, frozen while holdn is low
    always_ff @(posedge clk) begin
        if (!rstn) begin
            issued <= '0;
        end else if (holdn) begin
            issued <= issue_next;
        end
    end

endmodule

`default_nettype wire

//--- sprw_pipe/sprw_lane_alu.sv
`timescale 1ns/1ps
`default_nettype none

module sprw_lane_alu (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   holdn,
    input  wire sprw_ops_pkg::issue_t   issued,
    output sprw_ops_pkg::lane_stage_t   staged
);

    sprw_types_pkg::wide_vec_t wide_next;
    sprw_ops_pkg::lane_stage_t stage_next;

    // widen a lane, sign bit copied only in signed mode
    function automatic sprw_types_pkg::wide_t extend(sprw_types_pkg::lane_t v, logic sgn);
        sprw_types_pkg::wide_t z;
        z = {{(sprw_types_pkg::WIDE_W - sprw_types_pkg::LANE_W){sgn & v[sprw_types_pkg::LANE_W-1]}},
             v};
        return z;
    endfunction

    // clip to the byte range of the selected signedness
    function automatic sprw_types_pkg::wide_t clip(sprw_types_pkg::wide_t v, logic sgn, logic sat);
        sprw_types_pkg::wide_t z;
        z = v;
        if (sat) begin
            if (sgn) begin
                if (signed'(v) > 127)
                    z = 16'h007F;
                else if (signed'(v) < -128)
                    z = 16'hFF80;
            end else begin
                // unsigned sub can go below zero
                if (signed'(v) > 255)
                    z = 16'h00FF;
                else if (signed'(v) < 0)
                    z = 16'h0000;
            end
        end
        return z;
    endfunction

    function automatic sprw_types_pkg::wide_t lane_calc(sprw_types_pkg::lane_t a,
                                                        sprw_types_pkg::lane_t b,
                                                        sprw_ops_pkg::instr_t ins);
        sprw_types_pkg::wide_t ea;
        sprw_types_pkg::wide_t eb;
        sprw_types_pkg::wide_t res;
        ea = extend(a, ins.lane_signed);
        eb = extend(b, ins.lane_signed);
        // widened operands compare correctly as signed in both modes
        case (ins.lane_op)
            sprw_ops_pkg::LOP_PASS: res = ea;
            sprw_ops_pkg::LOP_ADD:  res = clip(ea + eb, ins.lane_signed, ins.sat);
            sprw_ops_pkg::LOP_SUB:  res = clip(ea - eb, ins.lane_signed, ins.sat);
            sprw_ops_pkg::LOP_MAX:  res = (signed'(ea) > signed'(eb)) ? ea : eb;
            sprw_ops_pkg::LOP_MIN:  res = (signed'(ea) > signed'(eb)) ? eb : ea;
            sprw_ops_pkg::LOP_AND:  res = extend(a & b, 1'b0);
            sprw_ops_pkg::LOP_OR:   res = extend(a | b, 1'b0);
            sprw_ops_pkg::LOP_XOR:  res = extend(a ^ b, 1'b0);
            sprw_ops_pkg::LOP_NAND: res = extend(~(a & b), 1'b0);
            sprw_ops_pkg::LOP_NOR:  res = extend(~(a | b), 1'b0);
            sprw_ops_pkg::LOP_XNOR: res = extend(~(a ^ b), 1'b0);
            sprw_ops_pkg::LOP_MOVB: res = eb;
            default:                res = '0;
        endcase
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < sprw_types_pkg::LANES; i++) begin
            wide_next[i] = lane_calc(issued.ra[i], issued.rb[i], issued.instr);
        end
    end

    always_comb begin
        stage_next.wide       = wide_next;
        stage_next.red_op     = issued.instr.red_op;
        stage_next.red_signed = issued.instr.red_signed;
        stage_next.sat        = issued.instr.sat;
        stage_next.rc_we      = issued.instr.rc_we;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            staged <= '0;
        end else if (holdn) begin
            staged <= stage_next;
        end
    end

endmodule

`default_nettype wire

//--- sprw_pipe/sprw_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module sprw_reduce (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    input  wire logic                        holdn,
    input  wire sprw_ops_pkg::lane_stage_t   staged,
    output sprw_types_pkg::word_t            result,
    output logic                             result_we
);

    sprw_types_pkg::word_t [sprw_types_pkg::LANES-1:0] lane_val;
    sprw_types_pkg::word_t sum_acc;
    sprw_types_pkg::word_t sum_res;
    sprw_types_pkg::word_t max_res;
    sprw_types_pkg::word_t min_res;
    sprw_types_pkg::lane_t xor_acc;
    sprw_types_pkg::word_t packed_low;
    sprw_types_pkg::word_t result_next;

    // each wide lane as a 32-bit number
    always_comb begin
        for (int i = 0; i < sprw_types_pkg::LANES; i++) begin
            if (staged.red_signed)
                lane_val[i] = {{16{staged.wide[i][sprw_types_pkg::WIDE_W-1]}}, staged.wide[i]};
            else
                lane_val[i] = {16'h0000, staged.wide[i]};
        end
    end

    always_comb begin
        sum_acc = '0;
        max_res = lane_val[0];
        min_res = lane_val[0];
        xor_acc = '0;
        for (int i = 0; i < sprw_types_pkg::LANES; i++) begin
            sum_acc = sum_acc + lane_val[i];
            xor_acc = xor_acc ^ staged.wide[i][sprw_types_pkg::LANE_W-1:0];
            packed_low[i*sprw_types_pkg::LANE_W +: sprw_types_pkg::LANE_W] =
                staged.wide[i][sprw_types_pkg::LANE_W-1:0];
            // zero-extended lanes stay positive, so a signed compare suits both modes
            if (signed'(lane_val[i]) > signed'(max_res))
                max_res = lane_val[i];
            if (signed'(lane_val[i]) < signed'(min_res))
                min_res = lane_val[i];
        end
    end

    // sum clipping to the byte range
    always_comb begin
        sum_res = sum_acc;
        if (staged.sat) begin
            if (staged.red_signed) begin
                if (signed'(sum_acc) > 127)
                    sum_res = 32'h0000_007F;
                else if (signed'(sum_acc) < -128)
                    sum_res = 32'hFFFF_FF80;
            end else if (sum_acc > 32'd255) begin
                sum_res = 32'h0000_00FF;
            end
        end
    end

    always_comb begin
        case (staged.red_op)
            sprw_ops_pkg::ROP_SUM: result_next = sum_res;
            sprw_ops_pkg::ROP_MAX: result_next = max_res;
            sprw_ops_pkg::ROP_MIN: result_next = min_res;
            sprw_ops_pkg::ROP_XOR: result_next = {24'h000000, xor_acc};
            default:               result_next = packed_low;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            result    <= '0;
            result_we <= 1'b0;
        end else if (holdn) begin
            result    <= result_next;
            result_we <= staged.rc_we;
        end
    end

endmodule

`default_nettype wire

//--- hw/sprw_top.sv
`timescale 1ns/1ps
`default_nettype none

module sprw_top (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   holdn,
    input  wire sprw_ops_pkg::instr_t   instr,
    input  wire sprw_types_pkg::word_t  ra,
    input  wire sprw_types_pkg::word_t  rb,
    output sprw_types_pkg::word_t       result,
    output logic                        result_we
);

    sprw_ops_pkg::issue_t      issued;
    sprw_ops_pkg::lane_stage_t staged;

    // operands and instruction into stage 1
    sprw_issue u_issue (
        .clk    (clk),
        .rstn   (rstn),
        .holdn  (holdn),
        .instr  (instr),
        .ra     (ra),
        .rb     (rb),
        .issued (issued)
    );

    sprw_lane_alu u_lane_alu (
        .clk    (clk),
        .rstn   (rstn),
        .holdn  (holdn),
        .issued (issued),
        .staged (staged)
    );

    // fold of the wide lanes, registered as the output
    sprw_reduce u_reduce (
        .clk       (clk),
        .rstn      (rstn),
        .holdn     (holdn),
        .staged    (staged),
        .result    (result),
        .result_we (result_we)
    );

endmodule

`default_nettype wire

//--- tests/sprw_chk.sv
`timescale 1ns/1ps
`default_nettype none

module sprw_chk (
    input wire logic                  clk,
    input wire logic                  rstn,
    input wire logic                  holdn,
    input wire sprw_types_pkg::word_t result,
    input wire logic                  result_we
);

    // output stage comes out of reset without a write
    a_reset_we: assert property (@(posedge clk) !rstn |=> !result_we)
        else $error("result_we high in the cycle after reset");

    // a low holdn freezes the output register
    a_hold_stable: assert property (@(posedge clk) (rstn && !holdn) |=>
                                    ($stable(result) && $stable(result_we)))
        else $error("result or result_we changed across an edge with holdn low");

    a_result_known: assert property (@(posedge clk) result_we |-> !$isunknown(result))
        else $error("result has unknown bits while result_we is high");

endmodule

bind sprw_top sprw_chk u_chk (
    .clk       (clk),
    .rstn      (rstn),
    .holdn     (holdn),
    .result    (result),
    .result_we (result_we)
);

`default_nettype wire

//--- tests/sprw_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sprw_tb;

    localparam int RESET_CYCLES = 5;
    localparam int MAX_GAP      = 5;

    logic                  clk = 1'b0;
    logic                  rstn;
    logic                  holdn;
    sprw_ops_pkg::instr_t  instr;
    sprw_types_pkg::word_t ra;
    sprw_types_pkg::word_t rb;
    sprw_types_pkg::word_t result;
    logic                  result_we;

    // stimulus table, one entry per row
    sprw_ops_pkg::instr_t  tab_instr [$];
    sprw_types_pkg::word_t tab_ra [$];
    sprw_types_pkg::word_t tab_rb [$];
    int                    tab_hold [$];
    sprw_types_pkg::word_t tab_res [$];
    logic                  tab_we [$];

    // row index per pipeline slot, -1 marks an idle slot
    int                    pend [$];
    int                    n_rows;
    int                    cur_row;
    logic                  row_valid;
    int                    rows_done = 0;
    int                    errors = 0;
    int                    checks = 0;
    int                    cycles = 0;
    int                    cycle_limit;
    logic                  prev_holdn = 1'b1;
    sprw_types_pkg::word_t prev_res;
    logic                  prev_we;

    sprw_top u_sprw_top (
        .clk       (clk),
        .rstn      (rstn),
        .holdn     (holdn),
        .instr     (instr),
        .ra        (ra),
        .rb        (rb),
        .result    (result),
        .result_we (result_we)
    );

    always #4 clk = ~clk;

    task automatic add_row(input sprw_ops_pkg::lane_op_e op, input sprw_ops_pkg::red_op_e rop,
                           input logic [3:0] flags, input sprw_types_pkg::word_t a,
                           input sprw_types_pkg::word_t b, input int hold,
                           input sprw_types_pkg::word_t res);
        sprw_ops_pkg::instr_t ins;
        ins.lane_op     = op;
        ins.lane_signed = flags[3];
        ins.sat         = flags[2];
        ins.red_op      = rop;
        ins.red_signed  = flags[1];
        ins.rc_we       = flags[0];
        tab_instr.push_back(ins);
        tab_ra.push_back(a);
        tab_rb.push_back(b);
        tab_hold.push_back(hold);
        tab_res.push_back(res);
        // write-enable follows the row's rc_we
        tab_we.push_back(flags[0]);
    endtask

    // flags are {lane_signed, sat, red_signed, rc_we}
    // columns after flags are ra, rb, hold gap before the row, expected result
    // a hold of -1 draws a random gap of 1 to 5 cycles
    task automatic build_table();
        // lane add and subtract, read back through the byte packing
        add_row(sprw_ops_pkg::LOP_ADD, sprw_ops_pkg::ROP_NONE, 4'b0101,
                32'h107F80C8, 32'h05019064, 0, 32'h1580FFFF);
        add_row(sprw_ops_pkg::LOP_ADD, sprw_ops_pkg::ROP_NONE, 4'b0001,
                32'h107F80C8, 32'h05019064, 0, 32'h1580102C);
        add_row(sprw_ops_pkg::LOP_SUB, sprw_ops_pkg::ROP_NONE, 4'b1101,
                32'h807F0580, 32'h01FF0A01, 2, 32'h807FFB80);
        add_row(sprw_ops_pkg::LOP_SUB, sprw_ops_pkg::ROP_NONE, 4'b1000,
                32'h807F0580, 32'h01FF0A01, 0, 32'h7F80FB7F);
        add_row(sprw_ops_pkg::LOP_SUB, sprw_ops_pkg::ROP_NONE, 4'b0101,
                32'h1005FF00, 32'h05100101, 0, 32'h0B00FE00);
        // max and min in both signedness modes
        add_row(sprw_ops_pkg::LOP_MAX, sprw_ops_pkg::ROP_NONE, 4'b1001,
                32'hFE8010FF, 32'hFD7F2001, 0, 32'hFE7F2001);
        add_row(sprw_ops_pkg::LOP_MAX, sprw_ops_pkg::ROP_NONE, 4'b0001,
                32'hFE8010FF, 32'hFD7F2001, 0, 32'hFE8020FF);
        add_row(sprw_ops_pkg::LOP_MIN, sprw_ops_pkg::ROP_NONE, 4'b1001,
                32'hFE8010FF, 32'hFD7F2001, 0, 32'hFD8010FF);
        add_row(sprw_ops_pkg::LOP_MIN, sprw_ops_pkg::ROP_NONE, 4'b0000,
                32'hFE8010FF, 32'hFD7F2001, 0, 32'hFD7F1001);
        // bytewise logic
        add_row(sprw_ops_pkg::LOP_AND, sprw_ops_pkg::ROP_NONE, 4'b0001,
                32'hF0CCAA0F, 32'h3CF055FF, 0, 32'h30C0000F);
        add_row(sprw_ops_pkg::LOP_OR, sprw_ops_pkg::ROP_NONE, 4'b0001,
                32'hF0CCAA0F, 32'h3CF055FF, 0, 32'hFCFCFFFF);
        add_row(sprw_ops_pkg::LOP_XOR, sprw_ops_pkg::ROP_NONE, 4'b1001,
                32'hF0CCAA0F, 32'h3CF055FF, 0, 32'hCC3CFFF0);
        add_row(sprw_ops_pkg::LOP_NAND, sprw_ops_pkg::ROP_NONE, 4'b0000,
                32'hF0CCAA0F, 32'h3CF055FF, 0, 32'hCF3FFFF0);
        add_row(sprw_ops_pkg::LOP_NOR, sprw_ops_pkg::ROP_NONE, 4'b0001,
                32'hF0CCAA0F, 32'h3CF055FF, 0, 32'h03030000);
        add_row(sprw_ops_pkg::LOP_XNOR, sprw_ops_pkg::ROP_NONE, 4'b0001,
                32'hF0CCAA0F, 32'h3CF055FF, 0, 32'h33C3000F);
        // reductions, with hold gaps back to back
        add_row(sprw_ops_pkg::LOP_PASS, sprw_ops_pkg::ROP_SUM, 4'b0001,
                32'hFF804001, 32'h00000000, 0, 32'h000001C0);
        add_row(sprw_ops_pkg::LOP_PASS, sprw_ops_pkg::ROP_SUM, 4'b0101,
                32'hFF804001, 32'h00000000, 1, 32'h000000FF);
        add_row(sprw_ops_pkg::LOP_PASS, sprw_ops_pkg::ROP_SUM, 4'b1011,
                32'hFF804001, 32'h00000000, 2, 32'hFFFFFFC0);
        add_row(sprw_ops_pkg::LOP_PASS, sprw_ops_pkg::ROP_SUM, 4'b1111,
                32'h80808010, 32'h00000000, 3, 32'hFFFFFF80);
        add_row(sprw_ops_pkg::LOP_PASS, sprw_ops_pkg::ROP_SUM, 4'b1111,
                32'h7F7F0102, 32'h00000000, 4, 32'h0000007F);
        add_row(sprw_ops_pkg::LOP_PASS, sprw_ops_pkg::ROP_MAX, 4'b1011,
                32'h80F08590, 32'h00000000, 5, 32'hFFFFFFF0);
        add_row(sprw_ops_pkg::LOP_PASS, sprw_ops_pkg::ROP_MIN, 4'b1010,
                32'h80F08590, 32'h00000000, -1, 32'hFFFFFF80);
        add_row(sprw_ops_pkg::LOP_MOVB, sprw_ops_pkg::ROP_MIN, 4'b1011,
                32'h12345678, 32'h05807F00, -1, 32'hFFFFFF80);
        add_row(sprw_ops_pkg::LOP_MOVB, sprw_ops_pkg::ROP_MAX, 4'b0001,
                32'h12345678, 32'h05807F00, 0, 32'h00000080);
        add_row(sprw_ops_pkg::LOP_ADD, sprw_ops_pkg::ROP_XOR, 4'b0001,
                32'h01020408, 32'h10204080, 0, 32'h000000FF);
        // lanes clip to -128, -128, 127, 127 and sum to -2
        add_row(sprw_ops_pkg::LOP_ADD, sprw_ops_pkg::ROP_SUM, 4'b1111,
                32'h7F7F8080, 32'h7F0180FF, 0, 32'hFFFFFFFE);
    endtask

    task automatic check_out(input sprw_types_pkg::word_t want_res, input logic want_we);
        checks++;
        if (result !== want_res) begin
            errors++;
            $display("Fail t=%0t result expected %h got %h", $time, want_res, result);
        end
        if (result_we !== want_we) begin
            errors++;
            $display("Fail t=%0t result_we expected %b got %b", $time, want_we, result_we);
        end
    endtask

    task automatic finish_run(input logic timed_out);
        $display("errors %0d in %0d checks", errors, checks);
        if (errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // outputs looked at mid-cycle, holdn here is what the next edge will use
    always @(negedge clk) begin
        int                    idx;
        sprw_types_pkg::word_t want_res;
        logic                  want_we;
        if (rstn) begin
            // no edge advanced the pipeline since the last look
            if (!prev_holdn) begin
                check_out(prev_res, prev_we);
            end
            if (holdn) begin
                idx      = pend.pop_front();
                want_res = (idx < 0) ? '0 : tab_res[idx];
                want_we  = (idx < 0) ? 1'b0 : tab_we[idx];
                check_out(want_res, want_we);
                if (idx >= 0) begin
                    rows_done++;
                end
                pend.push_back(row_valid ? cur_row : -1);
            end
        end
        prev_holdn = holdn;
        prev_res   = result;
        prev_we    = result_we;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d rows checked",
                     cycles, rows_done, n_rows);
            finish_run(1'b1);
        end
    end

    initial begin
        int                   gap;
        int                   seed;
        sprw_ops_pkg::instr_t busy_ins;
        seed = $urandom(32'ha330);
        build_table();
        n_rows      = tab_ra.size();
        cycle_limit = RESET_CYCLES + n_rows * (1 + MAX_GAP) + 3 + 20;
        // stage 1, stage 2 and output are all zero after reset
        repeat (3) pend.push_back(-1);
        // live instruction held during reset
        busy_ins       = '0;
        busy_ins.lane_op = sprw_ops_pkg::LOP_PASS;
        busy_ins.red_op  = sprw_ops_pkg::ROP_NONE;
        busy_ins.rc_we   = 1'b1;
        rstn      <= 1'b0;
        holdn     <= 1'b1;
        instr     <= busy_ins;
        ra        <= 32'hA55A3CC3;
        rb        <= 32'h0F0FF0F0;
        row_valid <= 1'b0;
        cur_row   <= 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn  <= 1'b1;
        instr <= '0;
        ra    <= '0;
        rb    <= '0;
        for (int k = 0; k < n_rows; k++) begin
            gap = (tab_hold[k] < 0) ? int'($urandom % MAX_GAP) + 1 : tab_hold[k];
            repeat (gap) begin
                @(posedge clk);
                holdn <= 1'b0;
            end
            @(posedge clk);
            holdn     <= 1'b1;
            instr     <= tab_instr[k];
            ra        <= tab_ra[k];
            rb        <= tab_rb[k];
            row_valid <= 1'b1;
            cur_row   <= k;
        end
        @(posedge clk);
        instr     <= '0;
        ra        <= '0;
        rb        <= '0;
        row_valid <= 1'b0;
        wait (rows_done == n_rows);
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

//--- sprw_simd.f
common/sprw_types_pkg.sv
common/sprw_ops_pkg.sv
sprw_pipe/sprw_issue.sv
sprw_pipe/sprw_lane_alu.sv
sprw_pipe/sprw_reduce.sv
hw/sprw_top.sv
tests/sprw_chk.sv
tests/sprw_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= sprw_tb
FILELIST  ?= sprw_simd.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJDIR)
